//--- rtl/debit_pkg.sv
// Debit table shared definitions
`default_nettype none

package debit_pkg;

    localparam int DATA_WIDTH = 8;                     // Width of one stored amount
    localparam int ADDR_WIDTH = 8;                     // Full table address
    localparam int BANK_BITS  = 2;                     // Low address bits that pick the bank
    localparam int NUM_BANKS  = 1 << BANK_BITS;
    localparam int ROW_BITS   = ADDR_WIDTH - BANK_BITS; // Address bits inside one bank

    // Cycles from a request on the top-level ports to its response
    // (router register, bank register, merger register)
    localparam int LATENCY = 3;

    typedef enum logic [1:0] {
        op_read  = 2'd0,                               // Return the entry without writing
        op_load  = 2'd1,                               // Store the amount as is
        op_debit = 2'd2                                // Store entry minus amount
    } debit_op_t;

    typedef struct packed {
        logic                  valid;
        debit_op_t             op;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] amount;
    } debit_req_t;

    typedef struct packed {
        logic                  valid;
        debit_op_t             op;
        logic [ROW_BITS-1:0]   row;
        logic [DATA_WIDTH-1:0] amount;
        logic                  blocked;                // Write dropped after losing a collision
    } bank_req_t;

    typedef struct packed {
        logic                  valid;
        logic [DATA_WIDTH-1:0] data;                   // Entry value after the operation
        logic                  underflow;              // Debit borrowed out of the top bit
        logic                  collided;               // Write was dropped
    } debit_rsp_t;

endpackage

`default_nettype wire

//--- rtl/debit_bank.sv
// Dual-port debit bank
`timescale 1ns/1ns
`default_nettype none

module debit_bank (
    input  logic                   clk,
    input  logic                   rst,
    input  debit_pkg::bank_req_t   req_a,
    input  debit_pkg::bank_req_t   req_b,
    output debit_pkg::debit_rsp_t  rsp_a,
    output debit_pkg::debit_rsp_t  rsp_b
);

    import debit_pkg::*;

    logic [DATA_WIDTH-1:0] mem [2**ROW_BITS];

    logic [DATA_WIDTH-1:0] old_a, old_b;
    logic [DATA_WIDTH:0]   sub_a, sub_b;             // Final borrow on top of the difference
    debit_rsp_t            next_a, next_b;
    logic                  wr_a, wr_b;

    // Ripple borrow subtractor giving minuend minus subtrahend
    function automatic logic [DATA_WIDTH:0] sub_borrow(
        input logic [DATA_WIDTH-1:0] minuend,
        input logic [DATA_WIDTH-1:0] subtrahend
    );
        logic [DATA_WIDTH:0]   borrow;
        logic [DATA_WIDTH-1:0] diff;
        borrow[0] = 1'b0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            diff[i]     = minuend[i] ^ subtrahend[i] ^ borrow[i];
            borrow[i+1] = (~minuend[i] & subtrahend[i]) |
                          ((~minuend[i] | subtrahend[i]) & borrow[i]);
        end
        return {borrow[DATA_WIDTH], diff};
    endfunction

    // Response for one port given the entry value before this cycle's writes
    function automatic debit_rsp_t respond(
        input bank_req_t             req,
        input logic [DATA_WIDTH-1:0] old,
        input logic [DATA_WIDTH:0]   sub
    );
        debit_rsp_t rsp;
        rsp.valid     = req.valid;
        rsp.data      = old;
        rsp.underflow = 1'b0;
        rsp.collided  = req.blocked;
        if (!req.blocked) begin
            case (req.op)
                op_load: rsp.data = req.amount;
                op_debit: begin
                    rsp.data      = sub[DATA_WIDTH-1:0];
                    rsp.underflow = sub[DATA_WIDTH];
                end
                default: rsp.data = old;
            endcase
        end
        return rsp;
    endfunction

    assign old_a = mem[req_a.row];                   // Both ports see the pre-write value
    assign old_b = mem[req_b.row];

    assign sub_a = sub_borrow(old_a, req_a.amount);
    assign sub_b = sub_borrow(old_b, req_b.amount);

    assign next_a = respond(req_a, old_a, sub_a);
    assign next_b = respond(req_b, old_b, sub_b);

    assign wr_a = req_a.valid && !req_a.blocked && (req_a.op != op_read);
    assign wr_b = req_b.valid && !req_b.blocked && (req_b.op != op_read);

    // Router never lets both ports write one row, so the order here does not matter
    always_ff @(posedge clk) begin
        if (!rst && wr_a) begin
            mem[req_a.row] <= next_a.data;
        end
        if (!rst && wr_b) begin
            mem[req_b.row] <= next_b.data;
        end
    end

    always_ff @(posedge clk) begin
        rsp_a <= next_a;
        rsp_b <= next_b;
        if (rst) begin
            rsp_a.valid <= 1'b0;
            rsp_b.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- rtl/bank_router.sv
// Request router for the bank array
`timescale 1ns/1ns
`default_nettype none

module bank_router (
    input  logic                                             clk,
    input  logic                                             rst,
    input  debit_pkg::debit_req_t                            req_a,
    input  debit_pkg::debit_req_t                            req_b,
    output debit_pkg::bank_req_t [debit_pkg::NUM_BANKS-1:0]  bank_req_a,
    output debit_pkg::bank_req_t [debit_pkg::NUM_BANKS-1:0]  bank_req_b,
    output logic [debit_pkg::BANK_BITS-1:0]                  sel_a,
    output logic [debit_pkg::BANK_BITS-1:0]                  sel_b
);

    import debit_pkg::*;

    debit_req_t           req_a_q, req_b_q;
    logic [BANK_BITS-1:0] bank_a, bank_b;
    logic [ROW_BITS-1:0]  row_a, row_b;
    logic                 wr_a, wr_b;
    logic                 clash;

    always_ff @(posedge clk) begin
        req_a_q <= req_a;
        req_b_q <= req_b;
        if (rst) begin
            req_a_q.valid <= 1'b0;
            req_b_q.valid <= 1'b0;
        end
    end

    assign bank_a = req_a_q.addr[BANK_BITS-1:0];
    assign bank_b = req_b_q.addr[BANK_BITS-1:0];
    assign row_a  = req_a_q.addr[ADDR_WIDTH-1:BANK_BITS];
    assign row_b  = req_b_q.addr[ADDR_WIDTH-1:BANK_BITS];

    assign wr_a = req_a_q.valid && (req_a_q.op != op_read);
    assign wr_b = req_b_q.valid && (req_b_q.op != op_read);

    // Port A wins when both ports write the same entry
    assign clash = wr_a && wr_b && (req_a_q.addr == req_b_q.addr);

    always_comb begin
        for (int i = 0; i < NUM_BANKS; i++) begin
            bank_req_a[i].valid   = req_a_q.valid && (bank_a == BANK_BITS'(i));
            bank_req_a[i].op      = req_a_q.op;
            bank_req_a[i].row     = row_a;
            bank_req_a[i].amount  = req_a_q.amount;
            bank_req_a[i].blocked = 1'b0;

            bank_req_b[i].valid   = req_b_q.valid && (bank_b == BANK_BITS'(i));
            bank_req_b[i].op      = req_b_q.op;
            bank_req_b[i].row     = row_b;
            bank_req_b[i].amount  = req_b_q.amount;
            bank_req_b[i].blocked = clash;
        end
    end

    // Second stage of the bank index that lines up with the bank response register
    always_ff @(posedge clk) begin
        sel_a <= bank_a;
        sel_b <= bank_b;
    end

endmodule

`default_nettype wire

//--- rtl/response_merger.sv
// Bank response merger
`timescale 1ns/1ns
`default_nettype none

module response_merger (
    input  logic                                              clk,
    input  logic                                              rst,
    input  debit_pkg::debit_rsp_t [debit_pkg::NUM_BANKS-1:0]  bank_rsp_a,
    input  debit_pkg::debit_rsp_t [debit_pkg::NUM_BANKS-1:0]  bank_rsp_b,
    input  logic [debit_pkg::BANK_BITS-1:0]                   sel_a,
    input  logic [debit_pkg::BANK_BITS-1:0]                   sel_b,
    output debit_pkg::debit_rsp_t                             rsp_a,
    output debit_pkg::debit_rsp_t                             rsp_b
);

    import debit_pkg::*;

    debit_rsp_t pick_a, pick_b;

    // Only the bank named by the index can hold a valid response for that port
    assign pick_a = bank_rsp_a[sel_a];
    assign pick_b = bank_rsp_b[sel_b];

    always_ff @(posedge clk) begin
        rsp_a <= pick_a;
        rsp_b <= pick_b;
        if (rst) begin
            rsp_a.valid <= 1'b0;
            rsp_b.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- rtl/debit_table.sv
// Banked debit table top level
`timescale 1ns/1ns
`default_nettype none

module debit_table (
    input  logic                   clk,
    input  logic                   rst,
    input  debit_pkg::debit_req_t  req_a,
    input  debit_pkg::debit_req_t  req_b,
    output debit_pkg::debit_rsp_t  rsp_a,
    output debit_pkg::debit_rsp_t  rsp_b
);

    import debit_pkg::*;

    bank_req_t  [NUM_BANKS-1:0] bank_req_a, bank_req_b;
    debit_rsp_t [NUM_BANKS-1:0] bank_rsp_a, bank_rsp_b;
    logic       [BANK_BITS-1:0] sel_a, sel_b;

    bank_router u_router (
        .clk        (clk),
        .rst        (rst),
        .req_a      (req_a),
        .req_b      (req_b),
        .bank_req_a (bank_req_a),
        .bank_req_b (bank_req_b),
        .sel_a      (sel_a),
        .sel_b      (sel_b)
    );

    // Bank g holds every address whose low bits equal g
    for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
        debit_bank u_bank (
            .clk   (clk),
            .rst   (rst),
            .req_a (bank_req_a[g]),
            .req_b (bank_req_b[g]),
            .rsp_a (bank_rsp_a[g]),
            .rsp_b (bank_rsp_b[g])
        );
    end

    response_merger u_merger (
        .clk        (clk),
        .rst        (rst),
        .bank_rsp_a (bank_rsp_a),
        .bank_rsp_b (bank_rsp_b),
        .sel_a      (sel_a),
        .sel_b      (sel_b),
        .rsp_a      (rsp_a),
        .rsp_b      (rsp_b)
    );

endmodule

`default_nettype wire

//--- bench/debit_table_assertions.sv
// Debit table port assertions
`timescale 1ns/1ns
`default_nettype none

module debit_table_assertions (
    input logic                  clk,
    input logic                  rst,
    input debit_pkg::debit_req_t req_a,
    input debit_pkg::debit_req_t req_b,
    input debit_pkg::debit_rsp_t rsp_a,
    input debit_pkg::debit_rsp_t rsp_b
);

    import debit_pkg::*;

    // Reset in any of the last three cycles leaves the pipeline empty
    quiet_in_reset: assert property (@(posedge clk)
        ($past(rst, 1) || $past(rst, 2) || $past(rst, 3)) |-> !rsp_a.valid && !rsp_b.valid)
        else $error("response valid during reset or within three cycles after it");

    latency_a: assert property (@(posedge clk)
        !(rst || $past(rst, 1) || $past(rst, 2) || $past(rst, 3))
        |-> rsp_a.valid == $past(req_a.valid, LATENCY))
        else $error("rsp_a valid does not follow req_a valid by the fixed latency");

    latency_b: assert property (@(posedge clk)
        !(rst || $past(rst, 1) || $past(rst, 2) || $past(rst, 3))
        |-> rsp_b.valid == $past(req_b.valid, LATENCY))
        else $error("rsp_b valid does not follow req_b valid by the fixed latency");

    // Port A always wins a collision
    a_never_collides: assert property (@(posedge clk) disable iff (rst)
        !rsp_a.collided)
        else $error("collided set on port A");

endmodule

bind debit_table debit_table_assertions u_assertions (
    .clk   (clk),
    .rst   (rst),
    .req_a (req_a),
    .req_b (req_b),
    .rsp_a (rsp_a),
    .rsp_b (rsp_b)
);

`default_nettype wire

//--- bench/debit_table_tb.sv
// Debit table testbench
`timescale 1ns/1ns
`default_nettype none

module debit_table_tb;

    import debit_pkg::*;

    localparam string PATTERN_FILE = "bench/debit_patterns.txt";
    localparam int    RESET_CYCLES = 16;
    localparam int    MAX_PATTERNS = 128;

    logic       clk;
    logic       rst;
    debit_req_t req_a, req_b;
    debit_rsp_t rsp_a, rsp_b;

    debit_rsp_t exp_a_q [$];                      // Expected responses in request order
    debit_rsp_t exp_b_q [$];

    int         pat_test  [MAX_PATTERNS];
    debit_req_t pat_req_a [MAX_PATTERNS];
    debit_req_t pat_req_b [MAX_PATTERNS];
    debit_rsp_t pat_rsp_a [MAX_PATTERNS];
    debit_rsp_t pat_rsp_b [MAX_PATTERNS];
    int         num_pats;

    int seed;
    int cycle_count, cycle_limit;
    int pass_count, error_count, tests_run;
    int test_checks, test_errors;

    debit_table dut (
        .clk   (clk),
        .rst   (rst),
        .req_a (req_a),
        .req_b (req_b),
        .rsp_a (rsp_a),
        .rsp_b (rsp_b)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Run stopped at the limit of %0d cycles with responses missing", cycle_limit);
            check_idle("rsp_a", exp_a_q.size(), 1'b1);
            check_idle("rsp_b", exp_b_q.size(), 1'b1);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check_rsp(input string name, input debit_rsp_t got, input debit_rsp_t exp);
        int bad;
        bad = 0;
        if (got.data !== exp.data) begin
            $display("ERROR at %0t ns: %s.data is %02h, expected %02h",
                     $time, name, got.data, exp.data);
            bad++;
        end
        if (got.underflow !== exp.underflow) begin
            $display("ERROR at %0t ns: %s.underflow is %b, expected %b",
                     $time, name, got.underflow, exp.underflow);
            bad++;
        end
        if (got.collided !== exp.collided) begin
            $display("ERROR at %0t ns: %s.collided is %b, expected %b",
                     $time, name, got.collided, exp.collided);
            bad++;
        end
        test_checks++;
        if (bad == 0) begin
            pass_count++;
        end else begin
            error_count += bad;
            test_errors += bad;
        end
    endtask

    task automatic check_idle(input string name, input int pending, input logic at_end);
        if (!at_end && pending == 0) begin
            $display("%s gave a response at %0t ns with no request outstanding", name, $time);
            error_count++;
            test_errors++;
        end
        if (at_end && pending != 0) begin
            $display("%s still owes %0d responses at the end of the run", name, pending);
            error_count++;
        end
    endtask

    // Outputs are sampled mid-cycle away from the clock edge
    always @(negedge clk) begin
        if (rsp_a.valid === 1'b1) begin
            check_idle("rsp_a", exp_a_q.size(), 1'b0);
            if (exp_a_q.size() > 0) begin
                check_rsp("rsp_a", rsp_a, exp_a_q.pop_front());
            end
        end
        if (rsp_b.valid === 1'b1) begin
            check_idle("rsp_b", exp_b_q.size(), 1'b0);
            if (exp_b_q.size() > 0) begin
                check_rsp("rsp_b", rsp_b, exp_b_q.pop_front());
            end
        end
    end

    task automatic load_patterns;
        int                    fd;
        int                    fields;
        int                    t;
        string                 line;
        logic [1:0]            op_a, op_b;
        logic [ADDR_WIDTH-1:0] addr_a, addr_b;
        logic [DATA_WIDTH-1:0] amt_a, amt_b, data_a, data_b;
        logic                  va, vb, uf_a, uf_b, col_a, col_b;
        num_pats = 0;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the pattern file %s", PATTERN_FILE);
            error_count++;
        end else begin
            while (!$feof(fd) && num_pats < MAX_PATTERNS) begin
                line = "";
                fields = $fgets(line, fd);
                if (line.len() < 4 || line.getc(0) == "#") begin
                    continue;                     // Blank or column note
                end
                fields = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                 t, op_a, addr_a, amt_a, op_b, addr_b, amt_b, va, vb,
                                 data_a, uf_a, col_a, data_b, uf_b, col_b);
                if (fields != 15) begin
                    $display("Pattern line not understood: %s", line);
                    error_count++;
                end else begin
                    pat_test[num_pats]  = t;
                    pat_req_a[num_pats] = '{valid: va, op: debit_op_t'(op_a),
                                            addr: addr_a, amount: amt_a};
                    pat_req_b[num_pats] = '{valid: vb, op: debit_op_t'(op_b),
                                            addr: addr_b, amount: amt_b};
                    pat_rsp_a[num_pats] = '{valid: 1'b1, data: data_a,
                                            underflow: uf_a, collided: col_a};
                    pat_rsp_b[num_pats] = '{valid: 1'b1, data: data_b,
                                            underflow: uf_b, collided: col_b};
                    num_pats++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic idle_cycle;
        @(posedge clk);
        #2;
        req_a = '0;
        req_b = '0;
    endtask

    task automatic drive_pattern(input int i);
        @(posedge clk);
        #2;
        req_a = pat_req_a[i];
        req_b = pat_req_b[i];
        if (pat_req_a[i].valid) begin
            exp_a_q.push_back(pat_rsp_a[i]);
        end
        if (pat_req_b[i].valid) begin
            exp_b_q.push_back(pat_rsp_b[i]);
        end
    endtask

    task automatic report_test(input string label);
        $display("test %s: %0d checks, %0d errors", label, test_checks, test_errors);
        tests_run++;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic finish_test(input int number);
        idle_cycle();
        while (exp_a_q.size() > 0 || exp_b_q.size() > 0) begin
            idle_cycle();
        end
        report_test($sformatf("%0d", number));
    endtask

    // Requests during reset must never come back
    task automatic reset_phase;
        repeat (RESET_CYCLES - 1) begin
            @(posedge clk);
            #2;
            req_a.valid  = 1'b1;
            req_a.op     = op_load;
            req_a.addr   = ADDR_WIDTH'($random(seed));
            req_a.amount = DATA_WIDTH'($random(seed));
            req_b.valid  = 1'b1;
            req_b.op     = op_debit;
            req_b.addr   = ADDR_WIDTH'($random(seed));
            req_b.amount = DATA_WIDTH'($random(seed));
        end
        @(posedge clk);
        #2;
        rst   = 1'b0;
        req_a = '0;
        req_b = '0;
        repeat (LATENCY + 1) idle_cycle();
        report_test("reset");
    endtask

    initial begin
        int gap;
        clk         = 1'b0;
        rst         = 1'b1;
        req_a       = '0;
        req_b       = '0;
        seed        = 32'hfedf;
        cycle_count = 0;
        pass_count  = 0;
        error_count = 0;
        tests_run   = 0;
        test_checks = 0;
        test_errors = 0;
        load_patterns();
        cycle_limit = num_pats * (LATENCY + 4) + 100;
        reset_phase();
        for (int i = 0; i < num_pats; i++) begin
            if (i > 0 && pat_test[i] != pat_test[i-1]) begin
                finish_test(pat_test[i-1]);
                gap = $unsigned($random(seed)) % 4;   // 0 to 3 idle cycles between tests
                repeat (gap) idle_cycle();
            end
            drive_pattern(i);
        end
        if (num_pats > 0) begin
            finish_test(pat_test[num_pats-1]);
        end else begin
            $display("No patterns were read, nothing was tested");
            error_count++;
        end
        $display("%0d tests, %0d checks passed, %0d errors", tests_run, pass_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/debit_patterns.txt
# test op_a addr_a amt_a op_b addr_b amt_b valid_a valid_b  a_data a_uf a_col  b_data b_uf b_col
# test is decimal, the rest hex; op 0 read, 1 load, 2 debit
# test 1 load then read on both ports across all banks
1 1 10 55 1 20 a0 1 1  55 0 0  a0 0 0
1 1 11 66 1 21 b1 1 1  66 0 0  b1 0 0
1 1 12 77 1 22 c2 1 1  77 0 0  c2 0 0
1 1 13 88 1 23 d3 1 1  88 0 0  d3 0 0
1 0 20 00 0 10 00 1 1  a0 0 0  55 0 0
1 0 21 00 0 11 00 1 1  b1 0 0  66 0 0
1 0 22 00 0 12 00 1 1  c2 0 0  77 0 0
1 0 23 00 0 13 00 1 1  d3 0 0  88 0 0
# test 2 debits without borrow
2 2 10 15 2 21 31 1 1  40 0 0  80 0 0
2 2 12 77 2 23 03 1 1  00 0 0  d0 0 0
2 2 10 0f 0 13 00 1 1  31 0 0  88 0 0
2 0 21 00 0 10 00 1 1  80 0 0  31 0 0
2 0 23 00 0 12 00 1 1  d0 0 0  00 0 0
# test 3 debits that wrap and set underflow
3 2 12 01 2 11 70 1 1  ff 1 0  f6 1 0
3 2 22 c3 2 13 ff 1 1  ff 1 0  89 1 0
3 0 11 00 0 12 00 1 1  f6 0 0  ff 0 0
3 0 13 00 0 22 00 1 1  89 0 0  ff 0 0
# test 4 same entry on both ports in one cycle
4 1 21 44 2 21 10 1 1  44 0 0  80 0 1
4 2 23 50 1 23 11 1 1  80 0 0  d0 0 1
4 2 10 32 2 10 01 1 1  ff 1 0  31 0 1
4 2 20 a1 0 20 00 1 1  ff 1 0  a0 0 0
4 0 22 00 1 22 5a 1 1  ff 0 0  5a 0 0
4 0 21 00 0 23 00 1 1  44 0 0  80 0 0
4 0 10 00 0 20 00 1 1  ff 0 0  ff 0 0
4 0 22 00 0 22 00 1 1  5a 0 0  5a 0 0
4 0 21 00 0 21 00 1 1  44 0 0  44 0 0
# test 5 back to back, same bank at different rows
5 1 31 01 1 35 02 1 1  01 0 0  02 0 0
5 1 32 03 1 36 04 1 1  03 0 0  04 0 0
5 1 30 09 1 37 0a 1 1  09 0 0  0a 0 0
5 2 31 01 2 35 03 1 1  00 0 0  ff 1 0
5 2 36 04 2 32 01 1 1  00 0 0  02 0 0
5 0 35 00 0 31 00 1 1  ff 0 0  00 0 0
5 0 32 00 0 36 00 1 1  02 0 0  00 0 0
5 0 30 00 0 37 00 1 1  09 0 0  0a 0 0
5 2 30 0a 0 00 00 1 0  ff 1 0  00 0 0
5 0 00 00 0 30 00 0 1  00 0 0  ff 0 0

//--- debit_table.f
rtl/debit_pkg.sv
rtl/debit_bank.sv
rtl/bank_router.sv
rtl/response_merger.sv
rtl/debit_table.sv
bench/debit_table_assertions.sv
bench/debit_table_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the debit table testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module debit_table_tb \
    -f debit_table.f \
    -o debit_table_sim

out=$(./obj_dir/debit_table_sim)
echo "$out"

if echo "$out" | grep -qx "TEST PASSED"; then
    exit 0
fi
exit 1
